/* build.f */
hdl/fpu_pkg.sv
hdl/fp_res_if.sv
hdl/fp_addsub.sv
hdl/fp_mult.sv
hdl/fp_cvt_itof.sv
hdl/fp_cvt_ftoi.sv
hdl/fpu.sv
dv/fpu_checker.sv
dv/fpu_tb.sv

/* dv/fpu_tb.sv */
`default_nettype none

module fpu_tb import fpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND = 32;
	localparam logic [2:0] FL_NONE = 3'b000;
	localparam logic [2:0] FL_OV = 3'b100;  // Flags are {overflow, underflow, nan}.
	localparam logic [2:0] FL_UN = 3'b010;
	localparam logic [2:0] FL_NAN = 3'b001;

	typedef struct {
		string    name;
		fpufunc_t func;
		float_t   a;
		float_t   b;
		float_t   r;
		logic [2:0] fl;
	} row_t;

	logic     clk_i, arst_n_i, valid_i;
	fpufunc_t func_i;
	float_t   opa_i, opb_i;
	logic     valid_o;
	float_t   result_o;
	logic     overflow_o, underflow_o, nan_o;

	row_t     table_q[$];
	row_t     pending_q[$];
	float_t   got_q[$];
	row_t     mon_row;
	logic [31:0] rand_vals[N_RAND];
	logic [31:0] rng;
	int       checks, errors, cycles, limit;

	fpu uut (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.valid_i     (valid_i),
		.func_i      (func_i),
		.opa_i       (opa_i),
		.opb_i       (opb_i),
		.valid_o     (valid_o),
		.result_o    (result_o),
		.overflow_o  (overflow_o),
		.underflow_o (underflow_o),
		.nan_o       (nan_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	function automatic row_t make_row(input string name, input fpufunc_t func,
		input float_t a, input float_t b, input float_t r, input logic [2:0] fl);
		row_t row;
		row.name = name;
		row.func = func;
		row.a = a;
		row.b = b;
		row.r = r;
		row.fl = fl;
		return row;
	endfunction

	task automatic add_row(input string name, input fpufunc_t func, input float_t a,
		input float_t b, input float_t r, input logic [2:0] fl);
		table_q.push_back(make_row(name, func, a, b, r, fl));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Reference conversion that is exact below 2^24 and truncates above.
	function automatic float_t int_to_float(input logic [31:0] x);
		logic [31:0] m, frac;
		int p;
		m = x[31] ? -x : x;
		if (m == 32'd0)
			return '0;
		p = 31;
		while (!m[p])
			p--;
		if (p > 23)
			frac = m >> (p - 23);
		else
			frac = m << (23 - p);
		return {x[31], 8'(127 + p), frac[22:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic issue(input row_t row);
		@(posedge clk_i);
		valid_i <= 1'b1;
		func_i <= row.func;
		opa_i <= row.a;
		opb_i <= row.b;
		pending_q.push_back(row);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		@(posedge clk_i);
		valid_i <= 1'b0;
		while (pending_q.size() != 0 && n < 6) begin
			@(posedge clk_i);
			n++;
		end
		if (pending_q.size() != 0) begin
			$display("valid_o never came for %0d outstanding operations", pending_q.size());
			errors += pending_q.size();
			pending_q.delete();
		end
	endtask

	// Results come back in issue order.
	always @(negedge clk_i) begin
		if (arst_n_i && valid_o) begin
			if (pending_q.size() == 0) begin
				errors++;
				$display("valid_o was high with no operation outstanding");
			end else begin
				mon_row = pending_q.pop_front();
				check(mon_row.name, mon_row.r, result_o);
				check({mon_row.name, " flags"}, {29'd0, mon_row.fl},
					{29'd0, overflow_o, underflow_o, nan_o});
				got_q.push_back(result_o);
			end
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, %0d operations never produced valid_o",
				cycles, pending_q.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		valid_i = 1'b0;
		func_i = FPU_CVTIS;
		opa_i = '0;
		opb_i = '0;
		arst_n_i = 1'b1;
		arst_n_i <= 1'b0;
		checks = 0;
		errors = 0;
		cycles = 0;
		limit = 1000;

		add_row("neg_pzero", FPU_NEG, 32'h0, 32'h0000_0000, 32'h8000_0000, FL_NONE);
		add_row("neg_nzero", FPU_NEG, 32'h0, 32'h8000_0000, 32'h0000_0000, FL_NONE);
		add_row("neg_pinf", FPU_NEG, 32'h0, 32'h7f80_0000, 32'hff80_0000, FL_NONE);
		add_row("neg_nan", FPU_NEG, 32'h0, 32'h7fc0_0001, 32'hffc0_0001, FL_NONE);
		add_row("neg_one", FPU_NEG, 32'h0, 32'h3f80_0000, 32'hbf80_0000, FL_NONE);
		add_row("add_1_2", FPU_ADD, 32'h3f80_0000, 32'h4000_0000, 32'h4040_0000, FL_NONE);
		add_row("sub_5_5", FPU_SUB, 32'h40a0_0000, 32'h40a0_0000, 32'h0000_0000, FL_NONE);
		add_row("sub_15_025", FPU_SUB, 32'h3fc0_0000, 32'h3e80_0000, 32'h3fa0_0000, FL_NONE);
		add_row("mul_3_05", FPU_MUL, 32'h4040_0000, 32'h3f00_0000, 32'h3fc0_0000, FL_NONE);
		add_row("mul_m2_4", FPU_MUL, 32'hc000_0000, 32'h4080_0000, 32'hc100_0000, FL_NONE);
		add_row("add_trunc", FPU_ADD, 32'h3f80_0000, 32'h3080_0000, 32'h3f80_0000, FL_NONE);
		add_row("sub_trunc", FPU_SUB, 32'h3f80_0000, 32'h3080_0000, 32'h3f7f_ffff, FL_NONE);
		add_row("sub_inf_inf", FPU_SUB, 32'h7f80_0000, 32'h7f80_0000, FP_QNAN, FL_NAN);
		add_row("add_inf_inf", FPU_ADD, 32'h7f80_0000, 32'h7f80_0000, 32'h7f80_0000, FL_NONE);
		add_row("add_max_max", FPU_ADD, 32'h7f7f_ffff, 32'h7f7f_ffff, 32'h7f80_0000, FL_OV);
		add_row("add_nan", FPU_ADD, 32'h7fc0_0000, 32'h3f80_0000, FP_QNAN, FL_NAN);
		add_row("mul_zero_inf", FPU_MUL, 32'h0000_0000, 32'h7f80_0000, FP_QNAN, FL_NAN);
		add_row("mul_max_2", FPU_MUL, 32'h7f7f_ffff, 32'h4000_0000, 32'h7f80_0000, FL_OV);
		add_row("mul_min_half", FPU_MUL, 32'h0080_0000, 32'h3f00_0000, 32'h0000_0000, FL_UN);
		add_row("mul_nan", FPU_MUL, 32'h3f80_0000, 32'h7fa0_0000, FP_QNAN, FL_NAN);
		add_row("cvtis_zero", FPU_CVTIS, 32'h0, 32'h0000_0000, 32'h0000_0000, FL_NONE);
		add_row("cvtis_one", FPU_CVTIS, 32'h0, 32'h0000_0001, 32'h3f80_0000, FL_NONE);
		add_row("cvtis_mone", FPU_CVTIS, 32'h0, 32'hffff_ffff, 32'hbf80_0000, FL_NONE);
		add_row("cvtis_2p24p1", FPU_CVTIS, 32'h0, 32'h0100_0001, 32'h4b80_0000, FL_NONE);
		add_row("cvtsi_375", FPU_CVTSI, 32'h0, 32'h4070_0000, 32'h0000_0003, FL_NONE);
		add_row("cvtsi_m375", FPU_CVTSI, 32'h0, 32'hc070_0000, 32'hffff_fffd, FL_NONE);
		add_row("cvtsi_2p31", FPU_CVTSI, 32'h0, 32'h4f00_0000, 32'h7fff_ffff, FL_OV);
		add_row("cvtsi_ninf", FPU_CVTSI, 32'h0, 32'hff80_0000, 32'h8000_0000, FL_OV);
		add_row("cvtsi_nan", FPU_CVTSI, 32'h0, 32'h7fc0_0000, 32'h0000_0000, FL_NAN);
		add_row("cvtsi_half", FPU_CVTSI, 32'h0, 32'h3f00_0000, 32'h0000_0000, FL_NONE);
		add_row("sqrt_rsvd", FPU_SQRT, 32'h3f80_0000, 32'h4080_0000, 32'h0, FL_NONE);
		add_row("div_rsvd", FPU_DIV, 32'h4000_0000, 32'h0000_0000, 32'h0, FL_NONE);
		limit = (table_q.size() + 2 * N_RAND + 3) * 2 + 20;

		repeat (2) @(posedge clk_i);
		arst_n_i <= 1'b1;

		foreach (table_q[i])
			issue(table_q[i]);
		wait_drain();

		// Random round trip with magnitudes in 1 .. 2^24-1.
		rng = 32'd26;
		got_q.delete();
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift(rng);
			rand_vals[i] = {8'd0, rng[23:0]};
			if (rand_vals[i] == 32'd0)
				rand_vals[i] = 32'd1;
			if (rng[31])
				rand_vals[i] = -rand_vals[i];
			issue(make_row($sformatf("cvtis_rand%0d", i), FPU_CVTIS, 32'h0, rand_vals[i],
				int_to_float(rand_vals[i]), FL_NONE));
			issue(make_row($sformatf("cvtis_negrand%0d", i), FPU_CVTIS, 32'h0, -rand_vals[i],
				int_to_float(-rand_vals[i]), FL_NONE));
		end
		wait_drain();

		if (got_q.size() != 2 * N_RAND) begin
			errors++;
			$display("Round trip skipped, only %0d conversions came back", got_q.size());
		end else begin
			for (int i = 0; i < N_RAND; i++) begin
				issue(make_row($sformatf("cvtsi_rand%0d", i), FPU_CVTSI, 32'h0, got_q[2 * i],
					rand_vals[i], FL_NONE));
				issue(make_row($sformatf("neg_rand%0d", i), FPU_NEG, 32'h0, got_q[2 * i],
					int_to_float(-rand_vals[i]), FL_NONE));
			end
			wait_drain();
		end

		repeat (4) @(posedge clk_i);  // Catch a stray valid_o.
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/fpu_checker.sv */
`default_nettype none

module fpu_checker import fpu_pkg::*; (
	input logic     clk_i,
	input logic     arst_n_i,
	input logic     valid_i,
	input fpufunc_t func_i,
	input logic     valid_out_i,
	input float_t   result_i,
	input logic     overflow_i,
	input logic     underflow_i,
	input logic     nan_i
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [1:0] since_rst;  // Saturating count of edges since reset release.

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			since_rst <= 2'd0;
		else if (since_rst != 2'd3)
			since_rst <= since_rst + 2'd1;
	end

	a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(since_rst == 2'd3) |-> (valid_out_i == $past(valid_i, 3)))
		else $error("valid_o does not follow valid_i by three cycles");

	// CVTSI reports a NaN input as integer zero.
	a_nan_word: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(valid_out_i && nan_i) |->
		(result_i == (($past(func_i, 3) == FPU_CVTSI) ? 32'h0 : FP_QNAN)))
		else $error("nan_o set with the wrong result word");

	a_flags: assert property (@(posedge clk_i) !(overflow_i && underflow_i))
		else $error("overflow_o and underflow_o both high");

	a_reset: assert property (@(posedge clk_i) !arst_n_i |->
		(!valid_out_i && !overflow_i && !underflow_i && !nan_i && result_i == '0))
		else $error("Outputs not cleared during reset");

endmodule

bind fpu fpu_checker u_checker (
	.clk_i       (clk_i),
	.arst_n_i    (arst_n_i),
	.valid_i     (valid_i),
	.func_i      (func_i),
	.valid_out_i (valid_o),
	.result_i    (result_o),
	.overflow_i  (overflow_o),
	.underflow_i (underflow_o),
	.nan_i       (nan_o)
);

`default_nettype wire

/* hdl/fpu.sv */
`default_nettype none

module fpu import fpu_pkg::*; (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     valid_i,
	input  fpufunc_t func_i,
	input  float_t   opa_i,
	input  float_t   opb_i,
	output logic     valid_o,
	output float_t   result_o,
	output logic     overflow_o,
	output logic     underflow_o,
	output logic     nan_o
);

	fp_res_if res_add ();
	fp_res_if res_mul ();
	fp_res_if res_itof ();
	fp_res_if res_ftoi ();

	logic     sub;
	logic     v1, v2;
	fpufunc_t f1, f2;
	float_t   b1, b2;

	float_t   sel_result;
	logic     sel_ov, sel_un, sel_nan;

	assign sub = func_i[0];  // ADD and SUB differ only in bit 0.

	fp_addsub u_addsub (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.sub_i    (sub),
		.opa_i    (opa_i),
		.opb_i    (opb_i),
		.res      (res_add)
	);

	fp_mult u_mult (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.opa_i    (opa_i),
		.opb_i    (opb_i),
		.res      (res_mul)
	);

	fp_cvt_itof u_itof (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.opb_i    (opb_i),
		.res      (res_itof)
	);

	fp_cvt_ftoi u_ftoi (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.opb_i    (opb_i),
		.res      (res_ftoi)
	);

	// Delay line matching the two unit stages.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			f1 <= FPU_CVTIS;
			f2 <= FPU_CVTIS;
		end else begin
			v1 <= valid_i;
			v2 <= v1;
			f1 <= func_i;
			f2 <= f1;
		end
	end

	always_ff @(posedge clk_i) begin
		b1 <= opb_i;
		b2 <= b1;
	end

	always_comb begin
		sel_result = '0;
		sel_ov = 1'b0;
		sel_un = 1'b0;
		sel_nan = 1'b0;
		case (f2)
			FPU_CVTIS: sel_result = res_itof.result;
			FPU_CVTSI: begin
				sel_result = res_ftoi.result;
				sel_ov = res_ftoi.overflow;
				sel_nan = res_ftoi.nan;
			end
			FPU_NEG: sel_result = b2 ^ 32'h8000_0000;
			FPU_ADD, FPU_SUB: begin
				sel_result = res_add.result;
				sel_ov = res_add.overflow;
				sel_un = res_add.underflow;
				sel_nan = res_add.nan;
			end
			FPU_MUL: begin
				sel_result = res_mul.result;
				sel_ov = res_mul.overflow;
				sel_un = res_mul.underflow;
				sel_nan = res_mul.nan;
			end
			default: ;  // SQRT and DIV are reserved, zero result.
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			result_o <= '0;
			overflow_o <= 1'b0;
			underflow_o <= 1'b0;
			nan_o <= 1'b0;
		end else begin
			valid_o <= v2;
			if (v2) begin  // Hold between results.
				result_o <= sel_result;
				overflow_o <= sel_ov;
				underflow_o <= sel_un;
				nan_o <= sel_nan;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/fp_cvt_ftoi.sv */
`default_nettype none

module fp_cvt_ftoi import fpu_pkg::*; (
	input  logic   clk_i,
	input  logic   arst_n_i,
	input  float_t opb_i,
	fp_res_if.unit res
);

	exp_t        e_unb;

	logic        s1_sign;
	man_t        s1_man;
	logic [4:0]  s1_sh;
	logic        s1_small, s1_ovf, s1_nan;

	logic [54:0] wide;
	logic [31:0] mag;

	assign e_unb = opb_i[30:23] - EXP_BIAS;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_small <= 1'b1;
			s1_ovf <= 1'b0;
			s1_nan <= 1'b0;
		end else begin
			s1_small <= (opb_i[30:23] < EXP_BIAS);  // Magnitude below 1.
			// Only -2^31 is representable at exponent 158.
			s1_ovf <= (opb_i[30:23] >= 8'd158) && !f_is_nan(opb_i) &&
				!(opb_i[31] && opb_i[30:23] == 8'd158 && opb_i[22:0] == 23'd0);
			s1_nan <= f_is_nan(opb_i);
		end
	end

	always_ff @(posedge clk_i) begin
		s1_sign <= opb_i[31];
		s1_man <= f_man(opb_i);
		s1_sh <= e_unb[4:0];
	end

	assign wide = {31'd0, s1_man} << s1_sh;
	assign mag = wide[54:23];  // Fraction bits drop off, truncating toward zero.

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res.overflow <= 1'b0;
			res.nan <= 1'b0;
		end else begin
			res.overflow <= s1_ovf;
			res.nan <= s1_nan;
		end
	end

	always_ff @(posedge clk_i) begin
		if (s1_nan || s1_small)
			res.result <= '0;
		else if (s1_ovf)
			res.result <= s1_sign ? 32'h8000_0000 : 32'h7fff_ffff;
		else
			res.result <= s1_sign ? (~mag + 32'd1) : mag;
	end

	assign res.underflow = 1'b0;

endmodule

`default_nettype wire

/* hdl/fp_cvt_itof.sv */
`default_nettype none

module fp_cvt_itof import fpu_pkg::*; (
	input  logic   clk_i,
	input  logic   arst_n_i,
	input  float_t opb_i,
	fp_res_if.unit res
);

	logic [31:0] abs_d;

	logic        s1_sign;
	logic [31:0] s1_abs;
	logic [4:0]  s1_lz;
	logic        s1_zero;

	logic [31:0] norm;
	exp_t        e_res;

	// Magnitude of -2^31 still fits as unsigned.
	assign abs_d = opb_i[31] ? (~opb_i + 32'd1) : opb_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			s1_zero <= 1'b1;
		else
			s1_zero <= (opb_i == 32'd0);
	end

	always_ff @(posedge clk_i) begin
		s1_sign <= opb_i[31];
		s1_abs <= abs_d;
		s1_lz <= lzc32(abs_d);
	end

	assign norm = s1_abs << s1_lz;
	assign e_res = 8'd158 - {3'd0, s1_lz};  // Bias plus 31.

	always_ff @(posedge clk_i) begin
		if (s1_zero)
			res.result <= '0;
		else
			res.result <= {s1_sign, e_res, norm[30:8]};  // Low bits truncated.
	end

	assign res.overflow = 1'b0;
	assign res.underflow = 1'b0;
	assign res.nan = 1'b0;

endmodule

`default_nettype wire

/* hdl/fp_mult.sv */
`default_nettype none

module fp_mult import fpu_pkg::*; (
	input  logic   clk_i,
	input  logic   arst_n_i,
	input  float_t opa_i,
	input  float_t opb_i,
	fp_res_if.unit res
);

	logic a_zero, b_zero, a_inf, b_inf;

	logic              s1_sign;
	logic signed [9:0] s1_exp;
	logic [47:0]       s1_prod;
	logic              s1_nan, s1_inf, s1_zero;

	logic [22:0]       frac;
	logic signed [9:0] e_res;
	float_t            r_d;
	logic              ov_d, un_d, qnan_d;

	always_comb begin
		a_zero = (opa_i[30:23] == 8'd0);
		b_zero = (opb_i[30:23] == 8'd0);
		a_inf = f_is_inf(opa_i);
		b_inf = f_is_inf(opb_i);
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_nan <= 1'b0;
			s1_inf <= 1'b0;
			s1_zero <= 1'b1;
		end else begin
			s1_nan <= f_is_nan(opa_i) | f_is_nan(opb_i) |
				(a_inf & b_zero) | (b_inf & a_zero);  // 0 x inf.
			s1_inf <= a_inf | b_inf;
			s1_zero <= a_zero | b_zero;
		end
	end

	always_ff @(posedge clk_i) begin
		s1_sign <= opa_i[31] ^ opb_i[31];
		s1_exp <= $signed({2'b00, opa_i[30:23]}) + $signed({2'b00, opb_i[30:23]}) -
			$signed({2'b00, EXP_BIAS});
		s1_prod <= f_man(opa_i) * f_man(opb_i);
	end

	always_comb begin
		// Product of two values in [1,2) needs at most one bit of shift.
		if (s1_prod[47]) begin
			frac = s1_prod[46:24];
			e_res = s1_exp + 10'sd1;
		end else begin
			frac = s1_prod[45:23];
			e_res = s1_exp;
		end

		ov_d = 1'b0;
		un_d = 1'b0;
		qnan_d = 1'b0;
		if (s1_nan) begin
			r_d = FP_QNAN;
			qnan_d = 1'b1;
		end else if (s1_inf) begin
			r_d = {s1_sign, EXP_MAX, 23'd0};
		end else if (s1_zero) begin
			r_d = {s1_sign, 31'd0};
		end else if (e_res >= 10'sd255) begin
			r_d = {s1_sign, EXP_MAX, 23'd0};
			ov_d = 1'b1;
		end else if (e_res <= 10'sd0) begin
			r_d = {s1_sign, 31'd0};  // Flush to signed zero.
			un_d = 1'b1;
		end else begin
			r_d = {s1_sign, e_res[7:0], frac};
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res.overflow <= 1'b0;
			res.underflow <= 1'b0;
			res.nan <= 1'b0;
		end else begin
			res.overflow <= ov_d;
			res.underflow <= un_d;
			res.nan <= qnan_d;
		end
	end

	always_ff @(posedge clk_i) begin
		res.result <= r_d;
	end

endmodule

`default_nettype wire

/* hdl/fp_addsub.sv */
`default_nettype none

module fp_addsub import fpu_pkg::*; (
	input  logic   clk_i,
	input  logic   arst_n_i,
	input  logic   sub_i,
	input  float_t opa_i,
	input  float_t opb_i,
	fp_res_if.unit res
);

	logic        sa, sb;
	exp_t        ea, eb, e_big, e_diff;
	man_t        ma, mb, m_big, m_small;
	logic        a_nan, b_nan, a_inf, b_inf;
	logic        a_big;
	logic [5:0]  shamt;
	logic [63:0] aligned;
	logic        sign_d, nan_d, inf_d;

	logic        s1_sign;
	exp_t        s1_exp;
	logic [31:0] s1_big, s1_small;
	logic        s1_sticky;
	logic        s1_sub;
	logic        s1_nan, s1_inf;

	logic [31:0] sum, norm;
	logic [4:0]  lz;
	logic signed [9:0] e_res;
	float_t      r_d;
	logic        ov_d, un_d, qnan_d;

	always_comb begin
		sa = opa_i[31];
		sb = opb_i[31] ^ sub_i;  // Subtraction adds the negated b.
		ea = opa_i[30:23];
		eb = opb_i[30:23];
		ma = f_man(opa_i);
		mb = f_man(opb_i);
		a_nan = f_is_nan(opa_i);
		b_nan = f_is_nan(opb_i);
		a_inf = f_is_inf(opa_i);
		b_inf = f_is_inf(opb_i);

		// Larger magnitude goes first.
		a_big = {ea, ma} >= {eb, mb};
		e_big = a_big ? ea : eb;
		e_diff = a_big ? (ea - eb) : (eb - ea);
		m_big = a_big ? ma : mb;
		m_small = a_big ? mb : ma;
		shamt = (e_diff > 8'd32) ? 6'd32 : e_diff[5:0];

		// Upper word is the aligned mantissa, lower word holds the shifted-out bits.
		aligned = {1'b0, m_small, 39'd0} >> shamt;

		nan_d = a_nan | b_nan | (a_inf & b_inf & (sa ^ sb));
		inf_d = a_inf | b_inf;
		if (a_inf)
			sign_d = sa;
		else if (b_inf)
			sign_d = sb;
		else
			sign_d = a_big ? sa : sb;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_nan <= 1'b0;
			s1_inf <= 1'b0;
		end else begin
			s1_nan <= nan_d;
			s1_inf <= inf_d;
		end
	end

	always_ff @(posedge clk_i) begin
		s1_sign <= sign_d;
		s1_exp <= e_big;
		s1_big <= {1'b0, m_big, 7'd0};
		s1_small <= aligned[63:32];
		s1_sticky <= |aligned[31:0];
		s1_sub <= sa ^ sb;
	end

	always_comb begin
		// Subtracting the sticky bit keeps truncation toward zero.
		if (s1_sub)
			sum = s1_big - s1_small - {31'd0, s1_sticky};
		else
			sum = s1_big + s1_small;
		lz = lzc32(sum);
		norm = sum << lz;
		e_res = $signed({2'b00, s1_exp}) + 10'sd1 - $signed({5'd0, lz});

		ov_d = 1'b0;
		un_d = 1'b0;
		qnan_d = 1'b0;
		if (s1_nan) begin
			r_d = FP_QNAN;
			qnan_d = 1'b1;
		end else if (s1_inf) begin
			r_d = {s1_sign, EXP_MAX, 23'd0};
		end else if (sum == 32'd0) begin
			r_d = '0;  // Exact cancellation is +0.
		end else if (e_res >= 10'sd255) begin
			r_d = {s1_sign, EXP_MAX, 23'd0};
			ov_d = 1'b1;
		end else if (e_res <= 10'sd0) begin
			r_d = {s1_sign, 31'd0};
			un_d = 1'b1;
		end else begin
			r_d = {s1_sign, e_res[7:0], norm[30:8]};
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res.overflow <= 1'b0;
			res.underflow <= 1'b0;
			res.nan <= 1'b0;
		end else begin
			res.overflow <= ov_d;
			res.underflow <= un_d;
			res.nan <= qnan_d;
		end
	end

	always_ff @(posedge clk_i) begin
		res.result <= r_d;
	end

endmodule

`default_nettype wire

/* hdl/fp_res_if.sv */
`default_nettype none

interface fp_res_if import fpu_pkg::*; ();

	float_t result;
	logic   overflow;
	logic   underflow;
	logic   nan;

	modport unit (output result, overflow, underflow, nan);
	modport sel  (input result, overflow, underflow, nan);

endinterface

`default_nettype wire

/* hdl/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

	typedef logic [31:0] float_t;  // IEEE single word, also a 32-bit integer.
	typedef logic [7:0]  exp_t;    // Biased exponent.
	typedef logic [23:0] man_t;    // Mantissa with the hidden bit.

	typedef enum logic [2:0] {
		FPU_CVTIS = 3'd0,
		FPU_CVTSI = 3'd1,
		FPU_SQRT  = 3'd2,
		FPU_NEG   = 3'd3,
		FPU_ADD   = 3'd4,
		FPU_SUB   = 3'd5,
		FPU_MUL   = 3'd6,
		FPU_DIV   = 3'd7
	} fpufunc_t;

	localparam float_t FP_QNAN  = 32'h7fc0_0000;
	localparam exp_t   EXP_MAX  = 8'hff;
	localparam exp_t   EXP_BIAS = 8'd127;

	// All-ones exponent with a nonzero fraction.
	function automatic logic f_is_nan(input float_t f);
		return (f[30:23] == EXP_MAX) && (f[22:0] != 23'd0);
	endfunction

	function automatic logic f_is_inf(input float_t f);
		return (f[30:23] == EXP_MAX) && (f[22:0] == 23'd0);
	endfunction

	// Subnormals read as zero.
	function automatic man_t f_man(input float_t f);
		man_t m;
		if (f[30:23] == 8'd0)
			m = '0;
		else
			m = {1'b1, f[22:0]};
		return m;
	endfunction

	// Leading zeros of a word, result is don't-care for zero input.
	function automatic logic [4:0] lzc32(input logic [31:0] x);
		logic [4:0] n;
		n = 5'd31;
		for (int i = 0; i < 32; i++) begin
			if (x[i])
				n = 5'(31 - i);  // Highest set bit wins.
		end
		return n;
	endfunction

endpackage

`default_nettype wire
